/* Bender.yml */
package:
  name: rom_loader

sources:
  - files:
      - source/rom_layout_pkg.sv
      - source/download_pkg.sv
      - source/rom_ext_decode.sv
      - source/rom_write_seq.sv
      - source/rom_page_map.sv
      - source/rom_loader.sv
  - target: simulation
    files:
      - verification/rom_loader_props.sv
      - verification/tb_rom_loader.sv

/* rom_loader.f */
source/rom_layout_pkg.sv
source/download_pkg.sv
source/rom_ext_decode.sv
source/rom_write_seq.sv
source/rom_page_map.sv
source/rom_loader.sv
verification/rom_loader_props.sv
verification/tb_rom_loader.sv

/* source/download_pkg.sv */
/*
 * Host download package
 * Widths of the host byte stream, the download class and the
 * states of the write sequencer.
 */
package download_pkg;

	//////////////////////////////
	// Host side widths
	//////////////////////////////

	localparam int dl_addr_w  = 25;
	localparam int dl_index_w = 8;
	localparam int dl_ext_w   = 16;

	// Low five index bits below this value mark a ROM download
	localparam int rom_index_limit = 4;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// What the current download is
	typedef enum logic [1:0] {
		dl_none      = 2'd0,
		dl_main      = 2'd1,
		dl_expansion = 2'd2
	} dl_class_e;

	// Write sequencer
	typedef enum logic [1:0] {
		st_idle        = 2'd0,
		st_wait_slot   = 2'd1,
		st_write       = 2'd2,
		st_second_bank = 2'd3
	} seq_state_e;

endpackage

/* source/rom_ext_decode.sv */
/*
 * ROM download decoder
 * Classifies a download at its start and turns the two-character
 * extension into the base page of an expansion ROM.
 * Also picks the model bank and the copy policy from the index,
 * and moves a combo image on to high ROM after its first block.
 */
module rom_ext_decode
	import rom_layout_pkg::*;
	import download_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  download,
	input  logic [dl_index_w-1:0] index,
	input  logic [dl_ext_w-1:0]   ext,
	input  logic                  page_advance,
	output dl_class_e             dl_class,
	output logic [page_w-1:0]     base_page,
	output logic                  combo,
	output model_bank_e           bank_sel,
	output logic                  dup_bank
);

	logic              download_q;
	logic              dl_start;
	logic              rom_index;
	logic [4:0]        hi_nib;
	logic [4:0]        lo_nib;
	logic [page_w-1:0] ext_page;

	// Returns {valid, nibble} for one upper case hex character
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		logic [4:0] res;
		res = '0;
		if (c >= "0" && c <= "9")
			res = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			res = {1'b1, c[3:0] + 4'd9};
		return res;
	endfunction

	assign dl_start  = download & ~download_q;
	assign rom_index = index[4:0] < rom_index_limit;

	// Bad characters keep the matching nibble of the spare page
	always_comb begin
		hi_nib   = hex_nibble(ext[15:8]);
		lo_nib   = hex_nibble(ext[7:0]);
		ext_page = page_spare;
		if (hi_nib[4])
			ext_page[7:4] = hi_nib[3:0];
		if (lo_nib[4])
			ext_page[3:0] = lo_nib[3:0];
		if (ext == "ZZ" || ext == "Z0")
			ext_page = '0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			dl_class   <= dl_none;
			base_page  <= page_spare;
			combo      <= 1'b0;
			bank_sel   <= bank_6128;
			dup_bank   <= 1'b0;
		end else begin
			download_q <= download;
			if (dl_start && rom_index) begin
				dl_class  <= (index == '0) ? dl_main : dl_expansion;
				base_page <= ext_page;
				combo     <= (index != '0) && (ext == "Z0");
				bank_sel  <= (&index[7:6]) ? bank_664 : bank_6128;
				// Boot names and manual loads go to both banks
				dup_bank  <= (index[7:6] == 2'b01) || (|index[5:0]);
			end else if (dl_start) begin
				// Not a ROM file, the sequencer ignores it
				dl_class <= dl_none;
				combo    <= 1'b0;
			end else if (page_advance) begin
				base_page <= page_combo_hi;
				combo     <= 1'b0;
			end
		end
	end

endmodule

/* source/rom_layout_pkg.sv */
/*
 * ROM layout package
 * Memory map of the loader target: word address split, page register,
 * fixed system ROM slot pages and the model bank encoding.
 * The upper half of the address space holds the high-ROM pages.
 */
package rom_layout_pkg;

	//////////////////////////////
	// Address split
	//////////////////////////////

	// Memory word address, top bit selects high ROM
	localparam int mem_addr_w = 23;

	// Page register, top bit selects the high-ROM half
	localparam int page_w = 9;

	// Byte offset within one 16 KB page
	localparam int block_w = 14;

	// Pages in the high-ROM half
	localparam int hi_pages = 256;

	//////////////////////////////
	// Fixed slot pages
	//////////////////////////////

	localparam logic [page_w-1:0] page_os     = 9'h000;
	localparam logic [page_w-1:0] page_basic  = 9'h100;
	localparam logic [page_w-1:0] page_amsdos = 9'h107;
	localparam logic [page_w-1:0] page_mf2    = 9'h0ff;

	// Unused high page, catches malformed extensions
	localparam logic [page_w-1:0] page_spare = 9'h1ee;

	// Combo image continues here, so the next block lands on high page 0
	localparam logic [page_w-1:0] page_combo_hi = 9'h1ff;

	// Model banks
	typedef enum logic [1:0] {
		bank_6128 = 2'd0,
		bank_664  = 2'd1
	} model_bank_e;

endpackage

/* source/rom_loader.sv */
/*
 * ROM loader top level
 * Takes the host ROM download stream and writes it into the
 * memory port. The decoder classifies each file, the sequencer
 * maps and paces the bytes, and the page map records which
 * high-ROM pages have been filled.
 */
module rom_loader
	import rom_layout_pkg::*;
	import download_pkg::*;
#(
	parameter int slot_div = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  download,
	input  logic [dl_index_w-1:0] index,
	input  logic [dl_ext_w-1:0]   ext,
	input  logic                  wr,
	input  logic [dl_addr_w-1:0]  addr,
	input  logic [7:0]            data,
	output logic                  dl_wait,
	output logic                  mem_wr,
	output logic [mem_addr_w-1:0] mem_addr,
	output model_bank_e           mem_bank,
	output logic [7:0]            mem_data,
	output logic [hi_pages-1:0]   rom_map
);

	dl_class_e         dl_class;
	logic [page_w-1:0] base_page;
	logic              combo;
	model_bank_e       bank_sel;
	logic              dup_bank;
	logic              page_advance;
	logic              page_done;
	logic [7:0]        page_idx;

	//////////////////////////////
	// Decode
	//////////////////////////////

	rom_ext_decode u_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.index        (index),
		.ext          (ext),
		.page_advance (page_advance),
		.dl_class     (dl_class),
		.base_page    (base_page),
		.combo        (combo),
		.bank_sel     (bank_sel),
		.dup_bank     (dup_bank)
	);

	//////////////////////////////
	// Execute
	//////////////////////////////

	rom_write_seq #(
		.slot_div (slot_div)
	) u_seq (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr           (wr),
		.addr         (addr),
		.data         (data),
		.dl_class     (dl_class),
		.base_page    (base_page),
		.combo        (combo),
		.bank_sel     (bank_sel),
		.dup_bank     (dup_bank),
		.dl_wait      (dl_wait),
		.mem_wr       (mem_wr),
		.mem_addr     (mem_addr),
		.mem_bank     (mem_bank),
		.mem_data     (mem_data),
		.page_done    (page_done),
		.page_idx     (page_idx),
		.page_advance (page_advance)
	);

	//////////////////////////////
	// Result
	//////////////////////////////

	rom_page_map u_page_map (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.page_done (page_done),
		.page_idx  (page_idx),
		.rom_map   (rom_map)
	);

endmodule

/* source/rom_page_map.sv */
/*
 * High-ROM page map
 * One sticky bit per high-ROM page, set when a write into that
 * page has completed. Cleared only by reset.
 */
module rom_page_map
	import rom_layout_pkg::*;
(
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        page_done,
	input  logic [$clog2(hi_pages)-1:0] page_idx,
	output logic [hi_pages-1:0]         rom_map
);

	//////////////////////////////
	// Page flags
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			rom_map <= '0;
		else if (page_done)
			rom_map[page_idx] <= 1'b1;
	end

endmodule

/* source/rom_write_seq.sv */
/*
 * ROM write sequencer
 * Maps each accepted host byte to a memory address and bank, then
 * issues the write on the memory slot strobe and holds the host off
 * with dl_wait until the write, and an optional copy to the second
 * bank, has closed. Reports filled high pages and combo progress.
 */
module rom_write_seq
	import rom_layout_pkg::*;
	import download_pkg::*;
#(
	parameter int slot_div = 8
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  wr,
	input  logic [dl_addr_w-1:0]  addr,
	input  logic [7:0]            data,
	input  dl_class_e             dl_class,
	input  logic [page_w-1:0]     base_page,
	input  logic                  combo,
	input  model_bank_e           bank_sel,
	input  logic                  dup_bank,
	output logic                  dl_wait,
	output logic                  mem_wr,
	output logic [mem_addr_w-1:0] mem_addr,
	output model_bank_e           mem_bank,
	output logic [7:0]            mem_data,
	output logic                  page_done,
	output logic [7:0]            page_idx,
	output logic                  page_advance
);

	localparam int cnt_w = $clog2(slot_div);

	logic [cnt_w-1:0]  slot_cnt;
	logic              slot_pre;
	seq_state_e        state;
	logic              accept;
	logic              mapped;
	logic [page_w-1:0] map_page;
	model_bank_e       map_bank;
	logic              copy_now;
	logic              high_half;

	//////////////////////////////
	// Slot strobe
	//////////////////////////////

	// Strobe is cnt == 0, actions are registered one cycle ahead
	assign slot_pre = slot_cnt == cnt_w'(slot_div - 1);

	always_ff @(posedge clk_sys) begin
		if (reset)
			slot_cnt <= '0;
		else if (slot_pre)
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	//////////////////////////////
	// Byte mapping
	//////////////////////////////

	always_comb begin
		mapped   = 1'b1;
		map_page = page_os;
		map_bank = bank_sel;
		if (dl_class == dl_main) begin
			map_bank = addr[16] ? bank_664 : bank_6128;
			case (addr[24:14])
				11'd0, 11'd4: map_page = page_os;
				11'd1, 11'd5: map_page = page_basic;
				11'd2, 11'd6: map_page = page_amsdos;
				11'd3, 11'd7: map_page = page_mf2;
				default:      mapped = 1'b0;
			endcase
		end else begin
			// Expansion pages wrap inside their half
			map_page = {base_page[8], base_page[7:0] + addr[21:14]};
		end
	end

	assign accept = wr && !dl_wait && state == st_idle && dl_class != dl_none;

	// Copy only from bank 0 of an expansion ROM
	assign copy_now = dl_class == dl_expansion && dup_bank && mem_bank == bank_6128;

	assign high_half = mem_addr[mem_addr_w-1];
	assign page_idx  = mem_addr[mem_addr_w-2:block_w];

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= st_idle;
			dl_wait      <= 1'b0;
			mem_wr       <= 1'b0;
			page_done    <= 1'b0;
			page_advance <= 1'b0;
		end else begin
			mem_wr       <= 1'b0;
			page_done    <= 1'b0;
			page_advance <= 1'b0;
			case (state)
				st_idle: begin
					// Also drops the wait of an unmapped byte
					dl_wait <= accept;
					if (accept && mapped)
						state <= st_wait_slot;
				end
				st_wait_slot: begin
					if (slot_pre) begin
						mem_wr <= 1'b1;
						state  <= st_write;
					end
				end
				st_write: begin
					if (slot_pre && copy_now) begin
						mem_wr <= 1'b1;
						state  <= st_second_bank;
					end else if (slot_pre) begin
						page_done    <= high_half;
						page_advance <= combo && (&mem_addr[block_w-1:0]);
						state        <= st_idle;
					end
				end
				st_second_bank: begin
					if (slot_pre) begin
						page_done    <= high_half;
						page_advance <= combo && (&mem_addr[block_w-1:0]);
						state        <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Payload of the pending write
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			mem_addr <= {map_page, addr[block_w-1:0]};
			mem_bank <= map_bank;
			mem_data <= data;
		end else if (state == st_write && slot_pre && copy_now) begin
			mem_bank <= bank_664;
		end
	end

endmodule

/* verification/rom_loader_props.sv */
/*
 * ROM loader checks
 * Bound to the loader top level. Mirrors the class, base page and
 * copy policy of each download from the host ports, predicts every
 * memory write and checks mapping, pacing and page marking.
 */
module rom_loader_props
	import rom_layout_pkg::*;
	import download_pkg::*;
(
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  download,
	input logic [dl_index_w-1:0] index,
	input logic [dl_ext_w-1:0]   ext,
	input logic                  wr,
	input logic [dl_addr_w-1:0]  addr,
	input logic [7:0]            data,
	input logic                  dl_wait,
	input logic                  mem_wr,
	input logic [mem_addr_w-1:0] mem_addr,
	input model_bank_e           mem_bank,
	input logic [7:0]            mem_data,
	input logic [hi_pages-1:0]   rom_map
);

	int unsigned           fail_cnt = 0;
	logic                  download_q;
	dl_class_e             cls;
	logic [page_w-1:0]     base;
	logic                  combo_pend;
	model_bank_e           file_bank;
	logic                  file_dup;
	logic                  accept;
	logic [10:0]           blk;
	logic [7:0]            hi_page;
	logic [page_w-1:0]     byte_page;
	model_bank_e           byte_bank;
	logic [1:0]            byte_writes;
	logic [mem_addr_w-1:0] exp_addr;
	logic [7:0]            exp_data;
	model_bank_e           exp_bank;
	logic [1:0]            exp_writes;
	logic [1:0]            wr_seen;
	model_bank_e           want_bank;

	// Hex character to nibble, anything else keeps the spare nibble
	function automatic logic [3:0] ext_nibble(input logic [7:0] c, input logic [3:0] keep);
		if (c inside {["0":"9"]})
			return 4'(c - "0");
		if (c inside {["A":"F"]})
			return 4'(c - "A" + 8'd10);
		return keep;
	endfunction

	// Reports one failed check and counts it
	task automatic count_failure(input string msg);
		$error("%s", msg);
		fail_cnt++;
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	assign accept    = wr && !dl_wait && cls != dl_none;
	assign blk       = addr[24:14];
	assign want_bank = (wr_seen == 2'd0) ? exp_bank : bank_664;

	// Expansion page is the base page plus the block, modulo 256
	assign hi_page = 8'((int'(base[7:0]) + int'(blk)) % 256);

	// Target of the byte now on the host bus
	always_comb begin
		byte_page   = {base[8], hi_page};
		byte_bank   = file_bank;
		byte_writes = (file_dup && file_bank == bank_6128) ? 2'd2 : 2'd1;
		if (cls == dl_main) begin
			byte_bank   = (blk >= 11'd4) ? bank_664 : bank_6128;
			byte_writes = (blk < 11'd8) ? 2'd1 : 2'd0;
			case (blk[1:0])
				2'd0:    byte_page = page_os;
				2'd1:    byte_page = page_basic;
				2'd2:    byte_page = page_amsdos;
				default: byte_page = page_mf2;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			cls        <= dl_none;
			combo_pend <= 1'b0;
			exp_writes <= 2'd0;
			wr_seen    <= 2'd0;
		end else begin
			download_q <= download;
			if (download && !download_q) begin
				cls <= (index[4:0] > 5'd3) ? dl_none :
					(index == '0) ? dl_main : dl_expansion;
				if (ext == "ZZ" || ext == "Z0")
					base <= '0;
				else
					base <= {page_spare[8], ext_nibble(ext[15:8], page_spare[7:4]),
						ext_nibble(ext[7:0], page_spare[3:0])};
				combo_pend <= (index[4:0] < 5'd4) && (index != '0) && (ext == "Z0");
				file_bank  <= (index[7:6] == 2'b11) ? bank_664 : bank_6128;
				file_dup   <= (index[7:6] == 2'b01) || (index[5:0] != 6'd0);
			end
			if (accept) begin
				exp_addr   <= {byte_page, addr[block_w-1:0]};
				exp_data   <= data;
				exp_bank   <= byte_bank;
				exp_writes <= byte_writes;
				wr_seen    <= 2'd0;
				// Last byte of a combo's first block moves it to high page 0
				if (combo_pend && (&addr[block_w-1:0])) begin
					base       <= page_combo_hi;
					combo_pend <= 1'b0;
				end
			end else if (mem_wr) begin
				wr_seen <= wr_seen + 2'd1;
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	assert property (@(posedge clk_sys) reset |=> !dl_wait && !mem_wr && rom_map == '0)
		else count_failure("dl_wait, mem_wr or rom_map not clear after reset");

	assert property (@(posedge clk_sys) disable iff (reset) mem_wr |-> dl_wait)
		else count_failure("mem_wr fired while dl_wait was low");

	assert property (@(posedge clk_sys) disable iff (reset) mem_wr |-> mem_addr == exp_addr)
		else count_failure($sformatf("error t=%0t mem_addr got %h expected %h",
			$time, $sampled(mem_addr), $sampled(exp_addr)));

	assert property (@(posedge clk_sys) disable iff (reset) mem_wr |-> mem_data == exp_data)
		else count_failure($sformatf("error t=%0t mem_data got %h expected %h",
			$time, $sampled(mem_data), $sampled(exp_data)));

	assert property (@(posedge clk_sys) disable iff (reset) mem_wr |-> mem_bank == want_bank)
		else count_failure($sformatf("error t=%0t mem_bank got %0d expected %0d",
			$time, $sampled(mem_bank), $sampled(want_bank)));

	// Unmapped main-image byte releases the host at once
	assert property (@(posedge clk_sys) disable iff (reset)
		(accept && byte_writes == 2'd0) |=> dl_wait ##1 !dl_wait)
		else count_failure("dl_wait did not fall one cycle after an unmapped byte");

	assert property (@(posedge clk_sys) disable iff (reset) $fell(dl_wait) |-> wr_seen == exp_writes)
		else count_failure($sformatf("error t=%0t mem_wr count got %0d expected %0d",
			$time, $sampled(wr_seen), $sampled(exp_writes)));

	assert property (@(posedge clk_sys) disable iff (reset)
		($fell(dl_wait) && exp_writes != 2'd0 && exp_addr[mem_addr_w-1])
		|-> rom_map[exp_addr[mem_addr_w-2:block_w]])
		else count_failure($sformatf("error t=%0t rom_map[%0d] got 0 expected 1",
			$time, $sampled(exp_addr[mem_addr_w-2:block_w])));

	assert property (@(posedge clk_sys) disable iff (reset)
		(rom_map & $past(rom_map)) == $past(rom_map))
		else count_failure("rom_map lost a page bit without a reset");

endmodule

/* verification/tb_rom_loader.sv */
/*
 * ROM loader testbench
 * Streams main, expansion, combo and out-of-range ROM downloads
 * into the loader. The bound checks judge the responses.
 */
module tb_rom_loader
	import rom_layout_pkg::*;
	import download_pkg::*;
();

	localparam int slot_div   = 8;
	localparam int wait_limit = 4 * slot_div;

	logic                  clk_sys;
	logic                  reset;
	logic                  download;
	logic [dl_index_w-1:0] index;
	logic [dl_ext_w-1:0]   ext;
	logic                  wr;
	logic [dl_addr_w-1:0]  addr;
	logic [7:0]            data;
	logic                  dl_wait;
	logic                  mem_wr;
	logic [mem_addr_w-1:0] mem_addr;
	model_bank_e           mem_bank;
	logic [7:0]            mem_data;
	logic [hi_pages-1:0]   rom_map;
	int unsigned           timeouts;

	bind rom_loader rom_loader_props u_props (.*);

	rom_loader #(.slot_div (slot_div)) dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic hold_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic open_file(input logic [dl_index_w-1:0] idx, input logic [dl_ext_w-1:0] e);
		@(posedge clk_sys);
		download <= 1'b1;
		index    <= idx;
		ext      <= e;
		// Decoder outputs settle one cycle after the edge
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic close_file();
		@(posedge clk_sys);
		download <= 1'b0;
	endtask

	// One host byte, then hold off until dl_wait drops
	task automatic write_byte(input logic [dl_addr_w-1:0] a, input logic [7:0] d);
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		wr   <= 1'b1;
		addr <= a;
		data <= d;
		@(posedge clk_sys);
		wr <= 1'b0;
		@(negedge clk_sys);
		while (dl_wait && cycles < wait_limit) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (dl_wait) begin
			timeouts++;
			$display("timeout: dl_wait still high %0d cycles after the write to %h", cycles, a);
		end
	endtask

	// Offset zero plus random offsets in each block
	task automatic load_blocks(input int first, input int last, input int per_block);
		logic [block_w-1:0] off;
		for (int b = first; b <= last; b++) begin
			for (int n = 0; n < per_block; n++) begin
				off = (n == 0) ? '0 : block_w'($urandom);
				write_byte((dl_addr_w'(b) << block_w) | dl_addr_w'(off), 8'($urandom));
			end
		end
	endtask

	initial begin
		reset    = 1'b1;
		download = 1'b0;
		index    = '0;
		ext      = '0;
		wr       = 1'b0;
		addr     = '0;
		data     = '0;
		timeouts = 0;
		void'($urandom(79));
		hold_reset();

		// Main image over the eight slot blocks, then two bytes past them
		open_file(8'h00, "RM");
		load_blocks(0, 7, 3);
		write_byte(25'h0020000, 8'h5a);
		write_byte(25'h0095234, 8'ha5);
		close_file();

		// Expansion at high page 1A, copied into both banks
		open_file(8'h01, "1A");
		load_blocks(0, 3, 2);
		close_file();

		// Bank 664 only, malformed extension
		open_file(8'hc0, "QQ");
		load_blocks(0, 1, 2);
		close_file();

		// Page wraps inside the high half
		open_file(8'h40, "F8");
		load_blocks(0, 9, 1);
		close_file();

		// Combo image, OS slot first, then high page 0 onwards
		open_file(8'h02, "Z0");
		write_byte(25'h0003fff, 8'h3c);
		load_blocks(1, 3, 1);
		close_file();

		open_file(8'h03, "ZZ");
		load_blocks(0, 1, 1);
		close_file();

		// Page map clears only here
		hold_reset();
		repeat (4) @(posedge clk_sys);

		$display("rom_loader run: %0d assertion failures, %0d timeouts",
			dut.u_props.fail_cnt, timeouts);
		if (dut.u_props.fail_cnt == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
